//--- tex_cache_pkg.sv
// ------------------------------
// texture cache shared definitions
// sizes, request kinds and the payload structs
// ------------------------------

`default_nettype none

package tex_cache_pkg;

	// ------------------------------
	// sizes
	// ------------------------------
	localparam int ADDR_X_WIDTH   = 8;
	localparam int ADDR_Y_WIDTH   = 8;
	localparam int BLK_X_SIZE     = 2;    // log2 of block width
	localparam int BLK_Y_SIZE     = 2;    // log2 of block height
	localparam int BLK_BEATS      = 16;
	localparam int TAG_ADDR_WIDTH = 4;
	localparam int DATA_WIDTH     = 16;
	localparam int USER_WIDTH     = 4;
	localparam int IMG_WIDTH      = 200;
	localparam int IMG_HEIGHT     = 120;
	localparam int QUE_PTR_WIDTH  = 2;

	// derived
	localparam int BLK_X_WIDTH    = ADDR_X_WIDTH - BLK_X_SIZE;
	localparam int BLK_Y_WIDTH    = ADDR_Y_WIDTH - BLK_Y_SIZE;
	localparam int LINE_X_BITS    = TAG_ADDR_WIDTH / 2;
	localparam int LINE_Y_BITS    = TAG_ADDR_WIDTH - LINE_X_BITS;
	localparam int LINE_NUM       = 1 << TAG_ADDR_WIDTH;
	localparam int TAG_WIDTH      = BLK_X_WIDTH + BLK_Y_WIDTH - TAG_ADDR_WIDTH;
	localparam int BEAT_WIDTH     = $clog2(BLK_BEATS);
	localparam int MEM_DEPTH      = LINE_NUM * BLK_BEATS;

	typedef enum logic [1:0] {
		KIND_HIT   = 2'd0,
		KIND_MISS  = 2'd1,
		KIND_BLANK = 2'd2
	} tex_kind_e;

	typedef struct packed {
		logic [USER_WIDTH-1:0]   user;
		logic [ADDR_X_WIDTH-1:0] x;
		logic [ADDR_Y_WIDTH-1:0] y;
	} tex_req_t;

	typedef struct packed {
		tex_kind_e                 kind;
		logic [USER_WIDTH-1:0]     user;
		logic [ADDR_X_WIDTH-1:0]   x;
		logic [ADDR_Y_WIDTH-1:0]   y;
		logic [TAG_ADDR_WIDTH-1:0] line;
	} tex_cmd_t;

	typedef struct packed {
		logic [USER_WIDTH-1:0] user;
		logic [DATA_WIDTH-1:0] data;
	} tex_resp_t;

endpackage

`default_nettype wire

//--- tex_cache_fifo.sv
// ------------------------------
// synchronous FIFO, depth 4
// payload type set per instance
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_cache_fifo #(
	parameter type T = logic [7:0]
) (
	input  logic clk,
	input  logic arst_n,

	input  T     s_data,
	input  logic s_valid,
	output logic s_ready,

	output T     m_data,
	output logic m_valid,
	input  logic m_ready
);

	import tex_cache_pkg::*;

	localparam int DEPTH = 1 << QUE_PTR_WIDTH;

	T                     mem [DEPTH];
	logic [QUE_PTR_WIDTH-1:0] wr_ptr;
	logic [QUE_PTR_WIDTH-1:0] rd_ptr;
	logic [QUE_PTR_WIDTH:0]   count;
	logic                     push;
	logic                     pop;

	// depth is a power of two, so the top count bit means full
	assign s_ready = !count[QUE_PTR_WIDTH];
	assign m_valid = (count != '0);
	assign m_data  = mem[rd_ptr];

	assign push = s_valid && s_ready;
	assign pop  = m_valid && m_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= s_data;
	end

endmodule

`default_nettype wire

//--- tex_cache_tag.sv
// ------------------------------
// texture cache tag stage
// classifies each request as hit, miss or blank
// against a direct-mapped tag store, runs the clear sweep
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_cache_tag (
	input  logic                    clk,
	input  logic                    arst_n,

	input  logic                    clear_start,
	output logic                    clear_busy,

	input  tex_cache_pkg::tex_req_t s_ar,
	input  logic                    s_arvalid,
	output logic                    s_arready,

	output tex_cache_pkg::tex_cmd_t cmd,
	output logic                    cmd_valid,
	input  logic                    cmd_ready,

	output logic                    status_hit,
	output logic                    status_miss,
	output logic                    status_blank
);

	import tex_cache_pkg::*;

	logic [LINE_NUM-1:0]       line_valid;
	logic [TAG_WIDTH-1:0]      line_tag [LINE_NUM];
	logic [TAG_ADDR_WIDTH-1:0] clear_cnt;

	logic [BLK_X_WIDTH-1:0]    blk_x;
	logic [BLK_Y_WIDTH-1:0]    blk_y;
	logic [TAG_ADDR_WIDTH-1:0] req_line;
	logic [TAG_WIDTH-1:0]      req_tag;
	logic                      req_blank;
	logic                      req_hit;
	tex_kind_e                 req_kind;
	logic                      accept;

	// ------------------------------
	// classify
	// ------------------------------
	assign blk_x    = s_ar.x[ADDR_X_WIDTH-1:BLK_X_SIZE];
	assign blk_y    = s_ar.y[ADDR_Y_WIDTH-1:BLK_Y_SIZE];
	assign req_line = {blk_y[LINE_Y_BITS-1:0], blk_x[LINE_X_BITS-1:0]};
	assign req_tag  = {blk_y[BLK_Y_WIDTH-1:LINE_Y_BITS], blk_x[BLK_X_WIDTH-1:LINE_X_BITS]};

	assign req_blank = (s_ar.x >= ADDR_X_WIDTH'(IMG_WIDTH))
	                || (s_ar.y >= ADDR_Y_WIDTH'(IMG_HEIGHT));
	assign req_hit   = line_valid[req_line] && (line_tag[req_line] == req_tag);

	always_comb begin
		if (req_blank)
			req_kind = KIND_BLANK;
		else if (req_hit)
			req_kind = KIND_HIT;
		else
			req_kind = KIND_MISS;
	end

	// one command register, stalls while it waits
	assign s_arready = !clear_busy && (!cmd_valid || cmd_ready);
	assign accept    = s_arvalid && s_arready;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clear_busy   <= 1'b0;
			clear_cnt    <= '0;
			line_valid   <= '0;
			cmd_valid    <= 1'b0;
			status_hit   <= 1'b0;
			status_miss  <= 1'b0;
			status_blank <= 1'b0;
		end else begin
			status_hit   <= accept && (req_kind == KIND_HIT);
			status_miss  <= accept && (req_kind == KIND_MISS);
			status_blank <= accept && (req_kind == KIND_BLANK);

			if (accept)
				cmd_valid <= 1'b1;
			else if (cmd_ready)
				cmd_valid <= 1'b0;

			if (clear_busy) begin
				line_valid[clear_cnt] <= 1'b0;    // one line per cycle
				clear_cnt             <= clear_cnt + 1'b1;
				if (clear_cnt == '1)
					clear_busy <= 1'b0;
			end else if (clear_start) begin
				clear_busy <= 1'b1;
				clear_cnt  <= '0;
			end

			// fill stage runs in order, so the line can be claimed now
			if (accept && (req_kind == KIND_MISS))
				line_valid[req_line] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && (req_kind == KIND_MISS))
			line_tag[req_line] <= req_tag;
		if (accept) begin
			cmd.kind <= req_kind;
			cmd.user <= s_ar.user;
			cmd.x    <= s_ar.x;
			cmd.y    <= s_ar.y;
			cmd.line <= req_line;
		end
	end

endmodule

`default_nettype wire

//--- tex_cache_fill.sv
// ------------------------------
// texture cache fill stage
// fetches missing blocks, holds the texel memory
// and queues responses in request order
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_cache_fill (
	input  logic                                   clk,
	input  logic                                   arst_n,

	input  logic [tex_cache_pkg::DATA_WIDTH-1:0]   param_blank_value,

	input  tex_cache_pkg::tex_cmd_t                que,
	input  logic                                   que_valid,
	output logic                                   que_ready,

	output logic [tex_cache_pkg::ADDR_X_WIDTH-1:0] m_araddrx,
	output logic [tex_cache_pkg::ADDR_Y_WIDTH-1:0] m_araddry,
	output logic                                   m_arvalid,
	input  logic                                   m_arready,
	input  logic [tex_cache_pkg::DATA_WIDTH-1:0]   m_rdata,
	input  logic                                   m_rvalid,
	input  logic                                   m_rlast,

	output tex_cache_pkg::tex_resp_t               s_r,
	output logic                                   s_rvalid,
	input  logic                                   s_rready
);

	import tex_cache_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_FILL,
		ST_RESP
	} fill_state_e;

	fill_state_e            state;
	logic [BEAT_WIDTH-1:0]  beat_cnt;
	tex_cmd_t               cmd_q;
	logic [DATA_WIDTH-1:0]  rd_data;
	logic [DATA_WIDTH-1:0]  data_mem [MEM_DEPTH];

	logic [BEAT_WIDTH-1:0]  que_offset;
	logic [BEAT_WIDTH-1:0]  cmd_offset;
	logic                   take;
	logic                   beat;

	tex_resp_t              rsp;
	logic                   rsp_valid;
	logic                   rsp_ready;

	// raster position inside the block
	assign que_offset = {que.y[BLK_Y_SIZE-1:0], que.x[BLK_X_SIZE-1:0]};
	assign cmd_offset = {cmd_q.y[BLK_Y_SIZE-1:0], cmd_q.x[BLK_X_SIZE-1:0]};

	// room in the response FIFO stays until the push, nothing else writes it
	assign que_ready = (state == ST_IDLE) && rsp_ready;
	assign take      = que_valid && que_ready;
	assign beat      = (state == ST_FILL) && m_rvalid;

	assign m_arvalid = (state == ST_ADDR);
	assign m_araddrx = {cmd_q.x[ADDR_X_WIDTH-1:BLK_X_SIZE], {BLK_X_SIZE{1'b0}}};
	assign m_araddry = {cmd_q.y[ADDR_Y_WIDTH-1:BLK_Y_SIZE], {BLK_Y_SIZE{1'b0}}};

	// ------------------------------
	// FSM
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (take)
						state <= (que.kind == KIND_MISS) ? ST_ADDR : ST_RESP;
				end
				ST_ADDR: begin
					if (m_arready) begin
						state    <= ST_FILL;
						beat_cnt <= '0;
					end
				end
				ST_FILL: begin
					if (m_rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (m_rlast)
							state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (rsp_ready)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ------------------------------
	// data path
	// ------------------------------
	always_ff @(posedge clk) begin
		if (take) begin
			cmd_q   <= que;
			rd_data <= (que.kind == KIND_BLANK) ? param_blank_value
			                                    : data_mem[{que.line, que_offset}];
		end else if (beat && (beat_cnt == cmd_offset)) begin
			rd_data <= m_rdata;    // requested texel straight off the burst
		end
	end

	always_ff @(posedge clk) begin
		if (beat)
			data_mem[{cmd_q.line, beat_cnt}] <= m_rdata;
	end

	always_comb begin
		rsp.user = cmd_q.user;
		rsp.data = rd_data;
	end

	assign rsp_valid = (state == ST_RESP);

	tex_cache_fifo #(
		.T (tex_resp_t)
	) u_rsp (
		.clk     (clk),
		.arst_n  (arst_n),
		.s_data  (rsp),
		.s_valid (rsp_valid),
		.s_ready (rsp_ready),
		.m_data  (s_r),
		.m_valid (s_rvalid),
		.m_ready (s_rready)
	);

endmodule

`default_nettype wire

//--- tex_cache_unit.sv
// ------------------------------
// texture cache unit top level
// tag stage, command queue and fill stage
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_cache_unit (
	input  logic                                   clk,
	input  logic                                   arst_n,

	input  logic                                   clear_start,
	output logic                                   clear_busy,

	input  logic [tex_cache_pkg::DATA_WIDTH-1:0]   param_blank_value,

	input  tex_cache_pkg::tex_req_t                s_ar,
	input  logic                                   s_arvalid,
	output logic                                   s_arready,
	output tex_cache_pkg::tex_resp_t               s_r,
	output logic                                   s_rvalid,
	input  logic                                   s_rready,

	output logic                                   status_hit,
	output logic                                   status_miss,
	output logic                                   status_blank,

	output logic [tex_cache_pkg::ADDR_X_WIDTH-1:0] m_araddrx,
	output logic [tex_cache_pkg::ADDR_Y_WIDTH-1:0] m_araddry,
	output logic                                   m_arvalid,
	input  logic                                   m_arready,
	input  logic [tex_cache_pkg::DATA_WIDTH-1:0]   m_rdata,
	input  logic                                   m_rvalid,
	input  logic                                   m_rlast
);

	import tex_cache_pkg::*;

	tex_cmd_t cmd;
	logic     cmd_valid;
	logic     cmd_ready;
	tex_cmd_t que;
	logic     que_valid;
	logic     que_ready;

	tex_cache_tag u_tag (
		.clk          (clk),
		.arst_n       (arst_n),
		.clear_start  (clear_start),
		.clear_busy   (clear_busy),
		.s_ar         (s_ar),
		.s_arvalid    (s_arvalid),
		.s_arready    (s_arready),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.status_hit   (status_hit),
		.status_miss  (status_miss),
		.status_blank (status_blank)
	);

	tex_cache_fifo #(
		.T (tex_cmd_t)
	) u_que (
		.clk     (clk),
		.arst_n  (arst_n),
		.s_data  (cmd),
		.s_valid (cmd_valid),
		.s_ready (cmd_ready),
		.m_data  (que),
		.m_valid (que_valid),
		.m_ready (que_ready)
	);

	tex_cache_fill u_fill (
		.clk               (clk),
		.arst_n            (arst_n),
		.param_blank_value (param_blank_value),
		.que               (que),
		.que_valid         (que_valid),
		.que_ready         (que_ready),
		.m_araddrx         (m_araddrx),
		.m_araddry         (m_araddry),
		.m_arvalid         (m_arvalid),
		.m_arready         (m_arready),
		.m_rdata           (m_rdata),
		.m_rvalid          (m_rvalid),
		.m_rlast           (m_rlast),
		.s_r               (s_r),
		.s_rvalid          (s_rvalid),
		.s_rready          (s_rready)
	);

endmodule

`default_nettype wire

//--- tex_cache_assertions.sv
// ------------------------------
// texture cache unit protocol assertions
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_cache_assertions (
	input logic                                   clk,
	input logic                                   arst_n,
	input logic                                   clear_busy,
	input logic                                   s_arready,
	input logic                                   s_rvalid,
	input logic                                   s_rready,
	input logic                                   status_hit,
	input logic                                   status_miss,
	input logic                                   status_blank,
	input logic                                   m_arvalid,
	input logic                                   m_arready,
	input logic [tex_cache_pkg::ADDR_X_WIDTH-1:0] m_araddrx,
	input logic [tex_cache_pkg::ADDR_Y_WIDTH-1:0] m_araddry
);

	int fail_ar = 0;
	int fail_clear = 0;
	int fail_status = 0;
	int fail_r = 0;

	a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddrx) && $stable(m_araddry))
		else begin
			$error("m_ar request dropped or changed before m_arready");
			fail_ar++;
		end

	a_clear_stall: assert property (@(posedge clk) disable iff (!arst_n)
		clear_busy |-> !s_arready)
		else begin
			$error("s_arready high during clear");
			fail_clear++;
		end

	a_status_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({status_hit, status_miss, status_blank}))
		else begin
			$error("more than one status pulse in a cycle");
			fail_status++;
		end

	a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		s_rvalid && !s_rready |=> s_rvalid)
		else begin
			$error("s_rvalid dropped before s_rready");
			fail_r++;
		end

endmodule

`default_nettype wire

//--- tb_tex_cache.sv
// ------------------------------
// texture cache unit testbench
// memory model, request stream from the stim file,
// in-order response and status checks
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_tex_cache;

	import tex_cache_pkg::*;

	localparam int CLK_HALF       = 2;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [DATA_WIDTH-1:0] BLANK_VALUE = 16'hdead;
	localparam logic [1:0] OP_REQ   = 2'd0;
	localparam logic [1:0] OP_CLEAR = 2'd1;
	localparam logic [1:0] OP_COUNT = 2'd2;
	localparam logic [ADDR_X_WIDTH-1:0] BLK_X_MASK = ~ADDR_X_WIDTH'((1 << BLK_X_SIZE) - 1);
	localparam logic [ADDR_Y_WIDTH-1:0] BLK_Y_MASK = ~ADDR_Y_WIDTH'((1 << BLK_Y_SIZE) - 1);

	typedef struct packed {
		logic [1:0]            op;
		tex_req_t              req;
		logic [1:0]            kind;
		logic [DATA_WIDTH-1:0] data;
	} stim_t;

	typedef struct packed {
		logic [1:0]            kind;
		logic [USER_WIDTH-1:0] user;
		logic [DATA_WIDTH-1:0] data;
	} expect_t;

	logic                    clk;
	logic                    arst_n;
	logic                    clear_start;
	logic                    clear_busy;
	logic [DATA_WIDTH-1:0]   param_blank_value;
	tex_req_t                s_ar;
	logic                    s_arvalid;
	logic                    s_arready;
	tex_resp_t               s_r;
	logic                    s_rvalid;
	logic                    s_rready;
	logic                    status_hit;
	logic                    status_miss;
	logic                    status_blank;
	logic [ADDR_X_WIDTH-1:0] m_araddrx;
	logic [ADDR_Y_WIDTH-1:0] m_araddry;
	logic                    m_arvalid;
	logic                    m_arready;
	logic [DATA_WIDTH-1:0]   m_rdata;
	logic                    m_rvalid;
	logic                    m_rlast;

	integer     seed = 32'h04d8_abd4;
	stim_t      stim_q[$];
	expect_t    exp_q[$];
	logic [1:0] status_q[$];
	logic [ADDR_Y_WIDTH+ADDR_X_WIDTH-1:0] fetch_q[$];
	int         check_errors = 0;
	int         timeout_errors = 0;
	int         hit_cnt = 0;
	int         miss_cnt = 0;
	int         blank_cnt = 0;
	int         fetch_cnt = 0;
	int         file_hit = 0;
	int         file_miss = 0;
	int         file_blank = 0;
	int         assert_errors;
	logic       abort = 1'b0;
	logic       send_done = 1'b0;

	tex_cache_unit u_dut (
		.clk (clk), .arst_n (arst_n),
		.clear_start (clear_start), .clear_busy (clear_busy),
		.param_blank_value (param_blank_value),
		.s_ar (s_ar), .s_arvalid (s_arvalid), .s_arready (s_arready),
		.s_r (s_r), .s_rvalid (s_rvalid), .s_rready (s_rready),
		.status_hit (status_hit), .status_miss (status_miss), .status_blank (status_blank),
		.m_araddrx (m_araddrx), .m_araddry (m_araddry),
		.m_arvalid (m_arvalid), .m_arready (m_arready),
		.m_rdata (m_rdata), .m_rvalid (m_rvalid), .m_rlast (m_rlast)
	);

	bind tex_cache_unit tex_cache_assertions u_assert (
		.clk (clk), .arst_n (arst_n),
		.clear_busy (clear_busy), .s_arready (s_arready),
		.s_rvalid (s_rvalid), .s_rready (s_rready),
		.status_hit (status_hit), .status_miss (status_miss), .status_blank (status_blank),
		.m_arvalid (m_arvalid), .m_arready (m_arready),
		.m_araddrx (m_araddrx), .m_araddry (m_araddry)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// status pulses in acceptance order
	always @(negedge clk) begin
		if (status_hit) begin
			status_q.push_back(KIND_HIT);
			hit_cnt++;
		end
		if (status_miss) begin
			status_q.push_back(KIND_MISS);
			miss_cnt++;
		end
		if (status_blank) begin
			status_q.push_back(KIND_BLANK);
			blank_cnt++;
		end
	end

	// ------------------------------
	// external memory model
	// ------------------------------
	initial begin : mem_model
		int                      delay;
		logic [ADDR_X_WIDTH-1:0] bx;
		logic [ADDR_Y_WIDTH-1:0] by;
		logic [3:0]              b4;
		m_arready = 1'b0;
		m_rvalid  = 1'b0;
		m_rlast   = 1'b0;
		m_rdata   = '0;
		forever begin
			@(posedge clk);
			#1 m_arready = (($random(seed) & 1) != 0);    // random address stall
			@(negedge clk);
			if (arst_n && m_arvalid && m_arready) begin
				bx = m_araddrx;
				by = m_araddry;
				fetch_cnt++;
				if (fetch_q.size() == 0) begin
					$display("fetch of block x %h y %h with no miss outstanding", bx, by);
					check_errors++;
				end else begin
					check_value("fetch_addr", 32'(fetch_q.pop_front()), 32'({by, bx}));
				end
				@(posedge clk);
				#1 m_arready = 1'b0;
				delay = 1 + ($random(seed) & 3);
				repeat (delay) @(posedge clk);
				for (int b = 0; b < BLK_BEATS; b++) begin
					b4 = 4'(b);
					@(posedge clk);
					#1;
					m_rvalid = 1'b1;
					m_rlast  = (b == BLK_BEATS - 1);
					// texel value is its y byte above its x byte
					m_rdata  = {by[ADDR_Y_WIDTH-1:BLK_Y_SIZE], b4[3:2],
					            bx[ADDR_X_WIDTH-1:BLK_X_SIZE], b4[1:0]};
				end
				@(posedge clk);
				#1;
				m_rvalid  = 1'b0;
				m_rlast   = 1'b0;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			check_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		timeout_errors++;
		abort = 1'b1;
	endtask

	task automatic read_stimulus;
		int    fd;
		int    n;
		int    user_v;
		int    x_v;
		int    y_v;
		int    data_v;
		string word;
		string kind_w;
		string rest;
		stim_t s;
		fd = $fopen("tex_cache_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open tex_cache_stim.txt");
			check_errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", word);
			if (n != 1)
				break;
			if (word == "#") begin    // comment line
				n = $fgets(rest, fd);
				continue;
			end
			n = $fscanf(fd, "%h %h %h %s %h", user_v, x_v, y_v, kind_w, data_v);
			if (n != 5) begin
				$display("malformed stimulus line starting with %s", word);
				check_errors++;
				break;
			end
			s.op       = (word == "req") ? OP_REQ : (word == "clear") ? OP_CLEAR : OP_COUNT;
			s.req.user = USER_WIDTH'(user_v);
			s.req.x    = ADDR_X_WIDTH'(x_v);
			s.req.y    = ADDR_Y_WIDTH'(y_v);
			s.kind     = (kind_w == "miss") ? KIND_MISS : (kind_w == "blank") ? KIND_BLANK
			                                                                  : KIND_HIT;
			s.data     = DATA_WIDTH'(data_v);
			stim_q.push_back(s);
		end
		$fclose(fd);
	endtask

	task automatic release_request;
		@(posedge clk);
		#1 s_arvalid = 1'b0;
	endtask

	task automatic drain_responses;
		int wait_cnt;
		wait_cnt = 0;
		while (exp_q.size() != 0 && !abort) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT_CYCLES)
				report_timeout("responses did not drain");
		end
	endtask

	task automatic send_request(input stim_t s);
		int      wait_cnt;
		expect_t e;
		e.kind = s.kind;
		e.user = s.req.user;
		e.data = s.data;
		exp_q.push_back(e);
		if (s.kind == KIND_HIT) begin
			file_hit++;
		end else if (s.kind == KIND_MISS) begin
			file_miss++;
			fetch_q.push_back({s.req.y & BLK_Y_MASK, s.req.x & BLK_X_MASK});    // block corner
		end else begin
			file_blank++;
		end
		@(posedge clk);
		#1;
		s_ar      = s.req;
		s_arvalid = 1'b1;
		wait_cnt  = 0;
		do begin
			@(negedge clk);
			wait_cnt++;
		end while (!s_arready && wait_cnt <= TIMEOUT_CYCLES && !abort);
		if (!s_arready && !abort)
			report_timeout("s_arready stayed low");
	endtask

	task automatic run_clear;
		int busy_cycles;
		release_request();
		drain_responses();
		@(posedge clk);
		#1 clear_start = 1'b1;
		@(posedge clk);
		#1 clear_start = 1'b0;
		@(negedge clk);
		busy_cycles = 0;
		while (clear_busy && !abort) begin
			check_value("clear_arready", 32'(0), 32'(s_arready));
			busy_cycles++;
			if (busy_cycles > TIMEOUT_CYCLES)
				report_timeout("clear_busy stayed high");
			@(negedge clk);
		end
		check_value("clear_cycles", LINE_NUM, busy_cycles);    // one line per cycle
	endtask

	task automatic check_counts;
		release_request();
		drain_responses();
		check_value("fetch_count", file_miss, fetch_cnt);
		check_value("hit_count", file_hit, hit_cnt);
		check_value("miss_count", file_miss, miss_cnt);
		check_value("blank_count", file_blank, blank_cnt);
	endtask

	task automatic run_sender;
		foreach (stim_q[i]) begin
			if (abort)
				break;
			case (stim_q[i].op)
				OP_REQ:   send_request(stim_q[i]);
				OP_CLEAR: run_clear();
				default:  check_counts();
			endcase
		end
		release_request();
		send_done = 1'b1;
	endtask

	task automatic run_receiver;
		int      idle;
		expect_t e;
		idle = 0;
		while (!abort && (!send_done || exp_q.size() != 0)) begin
			@(posedge clk);
			#1 s_rready = (($random(seed) & 1) != 0);    // random back-pressure
			@(negedge clk);
			if (s_rvalid && s_rready) begin
				idle = 0;
				if (exp_q.size() == 0) begin
					$display("response with user %h arrived with none outstanding", s_r.user);
					check_errors++;
				end else begin
					e = exp_q.pop_front();
					check_value("resp_user", 32'(e.user), 32'(s_r.user));
					check_value("resp_data", 32'(e.data), 32'(s_r.data));
					if (status_q.size() == 0) begin
						$display("response arrived without a status pulse");
						check_errors++;
					end else begin
						check_value("status_kind", 32'(e.kind), 32'(status_q.pop_front()));
					end
				end
			end else if (exp_q.size() != 0) begin
				idle++;
				if (idle > TIMEOUT_CYCLES)
					report_timeout("no response from the DUT");
			end
		end
		@(posedge clk);
		#1 s_rready = 1'b0;
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : main
		arst_n            = 1'b0;
		clear_start       = 1'b0;
		param_blank_value = BLANK_VALUE;
		s_ar              = '0;
		s_arvalid         = 1'b0;
		s_rready          = 1'b0;
		read_stimulus();
		repeat (5) @(posedge clk);
		#1 arst_n = 1'b1;
		@(negedge clk);
		check_value("reset_arready", 32'(1), 32'(s_arready));
		check_value("reset_clear_busy", 32'(0), 32'(clear_busy));
		check_value("reset_rvalid", 32'(0), 32'(s_rvalid));
		check_value("reset_arvalid", 32'(0), 32'(m_arvalid));
		fork
			run_sender();
			run_receiver();
		join
		assert_errors = u_dut.u_assert.fail_ar + u_dut.u_assert.fail_clear
		              + u_dut.u_assert.fail_status + u_dut.u_assert.fail_r;
		$display("errors: %0d checks, %0d timeouts, %0d assertions",
		         check_errors, timeout_errors, assert_errors);
		if (check_errors == 0 && timeout_errors == 0 && assert_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tex_cache_stim.txt
# cmd user x y kind data, numbers in hex
# kind is hit, miss or blank; clear and count ignore the other columns
req 1 05 09 miss 0905
req 2 06 0a hit 0a06
req 3 07 0b hit 0b07
req 4 04 08 hit 0804
req 5 c8 10 blank dead
req 6 10 78 blank dead
req 7 ff ff blank dead
req 8 00 00 miss 0000
req 9 40 00 miss 0040
req a 01 01 miss 0101
req b 41 02 miss 0241
req c 02 03 miss 0302
req d 43 03 miss 0343
count 0 00 00 - 0000
req e 42 01 hit 0142
clear 0 00 00 - 0000
req f 05 09 miss 0905
req 0 c7 77 miss 77c7
req 1 c6 76 hit 76c6
req 2 80 30 miss 3080
req 3 81 31 hit 3181
req 4 82 32 hit 3282
req 5 c8 00 blank dead
req 6 83 33 hit 3383
req 7 20 20 miss 2020
req 8 81 30 miss 3081
count 0 00 00 - 0000

//--- project.f
tex_cache_pkg.sv
tex_cache_fifo.sv
tex_cache_tag.sv
tex_cache_fill.sv
tex_cache_unit.sv
tex_cache_assertions.sv
tb_tex_cache.sv

//--- Makefile
# Verilator build and run for the texture cache unit

VERILATOR ?= verilator
TOP       ?= tb_tex_cache
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) project.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

run: $(BIN) tex_cache_stim.txt
	-./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
